//--- logic/usb_tx_pkg.sv
`default_nettype none

package usb_tx_pkg;

	// Full-speed bit timing
	localparam int CLKS_PER_BIT = 4;
	localparam int STB_CNT_W    = $clog2(CLKS_PER_BIT);

	localparam int BYTE_W      = 8;
	localparam int BIT_CNT_W   = 3;
	localparam int STUFF_LIMIT = 6;

	typedef logic [BYTE_W-1:0]    byte_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// Sent LSB first, gives KJKJKJKK on the line
	localparam byte_t SYNC_BYTE = 8'h80;

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		SOP  = 3'd1,
		DATA = 3'd2,
		EOP1 = 3'd3,
		EOP2 = 3'd4,
		WAIT = 3'd5
	} tx_state_e;

	typedef struct packed {
		logic active;
		logic tx_bit;
	} ser_bit_t;

	typedef struct packed {
		logic dp;
		logic dn;
		logic oe_n;
	} line_t;

endpackage

`default_nettype wire

//--- logic/tx_serializer.sv
`default_nettype none

module tx_serializer
	import usb_tx_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  i_tx_active,
	input  wire byte_t i_hold,
	output logic       o_bit_stb,
	output logic       o_byte_done,
	output ser_bit_t   o_bits
);

	logic [STB_CNT_W-1:0] div_cnt;
	logic                 tx_ip_sync;
	bit_cnt_t             bit_cnt;
	byte_t                hold_d;
	logic                 sd_raw;
	logic [2:0]           one_cnt;
	logic                 stuff;
	logic                 sd_bs;
	logic                 sft_done;
	logic                 sft_done_r;

	// Free-running bit strobe, one clock in CLKS_PER_BIT
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			div_cnt <= '0;
		else if (o_bit_stb)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign o_bit_stb = (div_cnt == STB_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			tx_ip_sync <= 1'b0;
		else if (o_bit_stb)
			tx_ip_sync <= i_tx_active;
	end

	////////////////////////////////////////
	// Shift counter and bit select
	////////////////////////////////////////

	// Index stalls for one strobe while a stuffed zero goes out
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			bit_cnt <= '0;
		else if (!tx_ip_sync)
			bit_cnt <= '0;
		else if (o_bit_stb && !stuff)
			bit_cnt <= bit_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		hold_d <= i_hold;
		if (!tx_ip_sync)
			sd_raw <= 1'b0;
		else
			sd_raw <= hold_d[bit_cnt];
	end

	// Last bit shifted, edge gives a single pulse
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sft_done   <= 1'b0;
			sft_done_r <= 1'b0;
		end
		else
		begin
			sft_done   <= !stuff && (bit_cnt == '1);
			sft_done_r <= sft_done;
		end
	end

	assign o_byte_done = sft_done & !sft_done_r;

	////////////////////////////////////////
	// Bit stuffer
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			one_cnt <= '0;
		else if (!tx_ip_sync)
			one_cnt <= '0;
		else if (o_bit_stb)
		begin
			if (!sd_raw || stuff)
				one_cnt <= '0;
			else
				one_cnt <= one_cnt + 1'b1;
		end
	end

	assign stuff = (one_cnt == 3'(STUFF_LIMIT));

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			sd_bs <= 1'b0;
		else if (o_bit_stb)
			sd_bs <= tx_ip_sync && !stuff && sd_raw;
	end

	assign o_bits = '{active: tx_ip_sync, tx_bit: sd_bs};

endmodule

`default_nettype wire

//--- logic/tx_line_driver.sv
`default_nettype none

module tx_line_driver
	import usb_tx_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     i_bit_stb,
	input  wire ser_bit_t i_bits,
	input  wire logic     i_ld_eop,
	input  wire logic     i_phy_mode,
	output logic          o_eop_done,
	output line_t         o_line
);

	logic nrzi;
	logic append_eop;
	logic eop_s1;
	logic eop_s2;
	logic eop_s3;
	logic eop_s4;
	logic txoe_r1;
	logic txoe_r2;

	// NRZI, a zero toggles the level, J while idle
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			nrzi <= 1'b1;
		else if (!i_bits.active || !txoe_r1)
			nrzi <= 1'b1;
		else if (i_bit_stb)
			nrzi <= i_bits.tx_bit ? nrzi : !nrzi;
	end

	////////////////////////////////////////
	// EOP sequencing
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			append_eop <= 1'b0;
		else if (i_ld_eop)
			append_eop <= 1'b1;
		else if (eop_s2)
			append_eop <= 1'b0;
	end

	// s3 is held for exactly two bit times by s4
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			eop_s1 <= 1'b0;
			eop_s2 <= 1'b0;
			eop_s3 <= 1'b0;
			eop_s4 <= 1'b0;
		end
		else if (i_bit_stb)
		begin
			eop_s1 <= append_eop;
			eop_s2 <= eop_s1;
			eop_s3 <= eop_s2 | (eop_s3 & !eop_s4);
			eop_s4 <= eop_s3;
		end
	end

	assign o_eop_done = eop_s3;

	// Output enable pipe, one J bit on each side
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			txoe_r1 <= 1'b0;
			txoe_r2 <= 1'b0;
		end
		else if (i_bit_stb)
		begin
			txoe_r1 <= i_bits.active;
			txoe_r2 <= txoe_r1;
		end
	end

	////////////////////////////////////////
	// Line registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			o_line <= '{dp: 1'b1, dn: 1'b0, oe_n: 1'b1};
		else if (i_bit_stb)
		begin
			o_line.oe_n <= !(txoe_r1 | txoe_r2);
			if (i_phy_mode)
			begin
				o_line.dp <= !eop_s3 & nrzi;
				o_line.dn <= !eop_s3 & !nrzi;
			end
			else
			begin
				// Single-ended, dn flags SE0
				o_line.dp <= nrzi;
				o_line.dn <= eop_s3;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/tx_packet_fsm.sv
`default_nettype none

module tx_packet_fsm
	import usb_tx_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire byte_t i_tx_data,
	input  wire logic  i_tx_valid,
	output logic       o_tx_ready,
	input  wire logic  i_bit_stb,
	input  wire logic  i_byte_done,
	input  wire logic  i_eop_done,
	output logic       o_tx_active,
	output byte_t      o_hold,
	output logic       o_ld_eop
);

	tx_state_e state;
	tx_state_e next_state;
	logic      tx_ready_d;
	logic      ld_sop_d;
	logic      ld_data_d;
	logic      ld_eop_d;
	logic      ld_data;
	logic      data_pend;

	////////////////////////////////////////
	// Handshake and load strobes
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			o_tx_ready <= 1'b0;
			ld_data    <= 1'b0;
		end
		else
		begin
			o_tx_ready <= tx_ready_d & i_tx_valid;
			ld_data    <= ld_data_d;
		end
	end

	// Byte is taken on the same edge that ends the ready pulse
	always_ff @(posedge clk)
	begin
		if (ld_sop_d)
			o_hold <= SYNC_BYTE;
		else if (ld_data)
			o_hold <= i_tx_data;
	end

	assign o_ld_eop = ld_eop_d;

	// Transmit in progress
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			o_tx_active <= 1'b0;
		else if (ld_sop_d)
			o_tx_active <= 1'b1;
		else if (i_eop_done)
			o_tx_active <= 1'b0;
	end

	// Valid may drop and come back while the old packet is still on the line;
	// only valid seen outside a packet counts as more data
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			data_pend <= 1'b0;
		else if (i_tx_valid && !o_tx_active)
			data_pend <= 1'b1;
		else if (!i_tx_valid)
			data_pend <= 1'b0;
	end

	////////////////////////////////////////
	// Packet FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		tx_ready_d = 1'b0;
		ld_sop_d   = 1'b0;
		ld_data_d  = 1'b0;
		ld_eop_d   = 1'b0;
		case (state)
			IDLE:
				if (i_tx_valid)
				begin
					ld_sop_d   = 1'b1;
					next_state = SOP;
				end
			SOP:
				if (i_byte_done)
				begin
					tx_ready_d = 1'b1;
					ld_data_d  = 1'b1;
					next_state = DATA;
				end
			DATA:
				if (i_byte_done)
				begin
					if (data_pend)
					begin
						tx_ready_d = 1'b1;
						ld_data_d  = 1'b1;
					end
					else
					begin
						ld_eop_d   = 1'b1;
						next_state = EOP1;
					end
				end
			EOP1:
				if (i_eop_done)
					next_state = EOP2;
			EOP2:
				if (!i_eop_done && i_bit_stb)
					next_state = WAIT;
			WAIT:
				if (i_bit_stb)
					next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/usb_tx_top.sv
`default_nettype none

module usb_tx_top
	import usb_tx_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire byte_t i_tx_data,
	input  wire logic  i_tx_valid,
	output logic       o_tx_ready,
	input  wire logic  i_phy_mode,
	output line_t      o_line
);

	logic     tx_active;
	byte_t    hold;
	logic     bit_stb;
	logic     byte_done;
	logic     ld_eop;
	logic     eop_done;
	ser_bit_t ser_bits;

	// Producer side, takes bytes and sequences the packet
	tx_packet_fsm u_fsm (
		.clk         (clk),
		.rst         (rst),
		.i_tx_data   (i_tx_data),
		.i_tx_valid  (i_tx_valid),
		.o_tx_ready  (o_tx_ready),
		.i_bit_stb   (bit_stb),
		.i_byte_done (byte_done),
		.i_eop_done  (eop_done),
		.o_tx_active (tx_active),
		.o_hold      (hold),
		.o_ld_eop    (ld_eop)
	);

	tx_serializer u_ser (
		.clk         (clk),
		.rst         (rst),
		.i_tx_active (tx_active),
		.i_hold      (hold),
		.o_bit_stb   (bit_stb),
		.o_byte_done (byte_done),
		.o_bits      (ser_bits)
	);

	// Consumer side, drives the wire
	tx_line_driver u_drv (
		.clk        (clk),
		.rst        (rst),
		.i_bit_stb  (bit_stb),
		.i_bits     (ser_bits),
		.i_ld_eop   (ld_eop),
		.i_phy_mode (i_phy_mode),
		.o_eop_done (eop_done),
		.o_line     (o_line)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
(
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam realtime HALF_PERIOD = 20ns;

	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD) o_clk = !o_clk;
	end

endmodule

`default_nettype wire

//--- testbench/usb_tx_monitor.sv
`default_nettype none

module usb_tx_monitor
	import usb_tx_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  i_tx_ready,
	input  wire logic  i_phy_mode,
	input  wire line_t i_line,
	output int         o_errs,
	output int         o_pkts
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int START_TIMEOUT = 2000;
	localparam int MAX_BITS      = 200;

	byte_t exp_q[$];
	int    errs;
	int    pkts;
	int    ready_total;
	int    ready_base;
	logic  stopped;

	assign o_errs = errs;
	assign o_pkts = pkts;

	task automatic push_expected(input byte_t b);
		exp_q.push_back(b);
	endtask

	task automatic value_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
		$display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
		errs++;
	endtask

	task automatic protocol_error(input string what);
		$display("%s at %0t", what, $time);
		errs++;
	endtask

	function automatic logic is_se0();
		if (i_phy_mode)
			return !i_line.dp && !i_line.dn;
		else
			return i_line.dn;
	endfunction

	task automatic final_check();
		if (exp_q.size() != 0)
			protocol_error($sformatf("%0d accepted bytes never appeared on the line", exp_q.size()));
	endtask

	// One pulse is visible at exactly one falling edge
	always @(negedge clk)
	begin
		if (rst === 1'b1 && i_tx_ready === 1'b1)
			ready_total++;
	end

	task automatic take_byte(input byte_t rx, input int idx);
		if (idx == 0)
		begin
			if (rx !== SYNC_BYTE)
				value_mismatch("sync_byte", SYNC_BYTE, rx);
		end
		else if (exp_q.size() == 0)
			protocol_error($sformatf("byte %h decoded with no byte expected", rx));
		else
		begin
			if (rx !== exp_q[0])
				value_mismatch("rx_byte", exp_q[0], rx);
			void'(exp_q.pop_front());
		end
	endtask

	////////////////////////////////////////
	// Packet decoder
	////////////////////////////////////////

	task automatic check_packet();
		logic  prev;
		logic  rx_bit;
		int    ones;
		int    nbits;
		int    nbytes;
		int    n;
		int    se0;
		logic  done;
		byte_t cur;
		prev   = 1'b1;
		ones   = 0;
		nbits  = 0;
		nbytes = 0;
		n      = 0;
		done   = 1'b0;
		cur    = '0;
		// Middle of the leading J bit
		repeat (2) @(negedge clk);
		if (i_line !== 3'b100)
			value_mismatch("o_line", 8'h04, 8'(i_line));
		while (!done && n < MAX_BITS)
		begin
			repeat (4) @(negedge clk);
			n++;
			if (i_line.oe_n)
			begin
				protocol_error("output enable released before any EOP");
				return;
			end
			else if (is_se0())
				done = 1'b1;
			else
			begin
				if (i_phy_mode && i_line.dp && i_line.dn)
					protocol_error("SE1 seen on the line");
				rx_bit = (i_line.dp == prev);
				prev   = i_line.dp;
				if (ones == STUFF_LIMIT)
				begin
					if (rx_bit)
						protocol_error("seventh consecutive one, stuffed zero missing");
					ones = 0;
				end
				else
				begin
					ones  = rx_bit ? ones + 1 : 0;
					cur   = {rx_bit, cur[BYTE_W-1:1]};
					nbits = nbits + 1;
					if (nbits == BYTE_W)
					begin
						take_byte(cur, nbytes);
						nbytes++;
						nbits = 0;
					end
				end
			end
		end
		if (!done)
		begin
			protocol_error("no EOP found within the bit limit");
			return;
		end
		if (nbits != 0)
			protocol_error($sformatf("packet ended with %0d leftover bits", nbits));

		// EOP, then one J bit, then the line is released
		se0 = 1;
		repeat (4) @(negedge clk);
		while (is_se0() && !i_line.oe_n && se0 < 4)
		begin
			se0++;
			repeat (4) @(negedge clk);
		end
		if (se0 != 2)
			protocol_error($sformatf("SE0 lasted %0d bit times instead of 2", se0));
		if (i_line !== 3'b100)
			value_mismatch("o_line", 8'h04, 8'(i_line));
		repeat (4) @(negedge clk);
		if (i_line !== 3'b101)
			value_mismatch("o_line", 8'h05, 8'(i_line));
		if (ready_total - ready_base != nbytes - 1)
			protocol_error($sformatf("%0d ready pulses for %0d data bytes",
				ready_total - ready_base, nbytes - 1));
		ready_base = ready_total;
		pkts++;
	endtask

	initial
	begin
		int n;
		errs        = 0;
		pkts        = 0;
		ready_total = 0;
		ready_base  = 0;
		stopped     = 1'b0;
		n           = 0;
		while (rst !== 1'b1 && n < START_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (rst !== 1'b1)
			protocol_error("reset was never released");
		else
		begin
			// Idle state right after reset
			@(negedge clk);
			if (i_tx_ready !== 1'b0)
				value_mismatch("o_tx_ready", 8'h00, 8'(i_tx_ready));
			if (i_line !== 3'b101)
				value_mismatch("o_line", 8'h05, 8'(i_line));
			while (!stopped)
			begin
				n = 0;
				while (i_line.oe_n !== 1'b0 && n < START_TIMEOUT)
				begin
					@(negedge clk);
					n++;
				end
				if (i_line.oe_n !== 1'b0)
				begin
					protocol_error("no packet start seen on the line");
					stopped = 1'b1;
				end
				else
					check_packet();
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/usb_tx_props.sv
`default_nettype none

module usb_tx_props
	import usb_tx_pkg::*;
(
	input wire logic  clk,
	input wire logic  rst,
	input wire logic  i_tx_ready,
	input wire line_t i_line
);
	timeunit 1ns;
	timeprecision 100ps;

	int          fail_cnt = 0;
	int unsigned clk_cnt;

	// Clocks counted since reset release
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			clk_cnt <= 0;
		else
			clk_cnt <= clk_cnt + 1;
	end

	ready_single: assert property (@(posedge clk) disable iff (!rst)
		i_tx_ready |=> !i_tx_ready)
		else
		begin
			fail_cnt++;
			$error("o_tx_ready high two clocks in a row");
		end

	// Released line idles at J
	idle_is_j: assert property (@(posedge clk) disable iff (!rst)
		i_line.oe_n |-> (i_line.dp && !i_line.dn))
		else
		begin
			fail_cnt++;
			$error("o_line not J while output enable is off");
		end

	// Line levels only move at the start of a bit time
	bit_time_stable: assert property (@(posedge clk) disable iff (!rst)
		(clk_cnt % CLKS_PER_BIT != 0) |-> $stable(i_line))
		else
		begin
			fail_cnt++;
			$error("o_line changed away from a bit boundary");
		end

endmodule

bind usb_tx_top usb_tx_props u_props (
	.clk        (clk),
	.rst        (rst),
	.i_tx_ready (o_tx_ready),
	.i_line     (o_line)
);

`default_nettype wire

//--- testbench/usb_tx_tb.sv
`default_nettype none

module usb_tx_tb
	import usb_tx_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_PKTS      = 20;
	localparam int MAX_PKT_LEN   = 8;
	localparam int RST_CYCLES    = 16;
	localparam int READY_TIMEOUT = 300;
	localparam int PKT_TIMEOUT   = 400;

	logic   clk;
	logic   rst;
	byte_t  tx_data;
	logic   tx_valid;
	logic   tx_ready;
	logic   phy_mode;
	line_t  line;
	int     mon_errs;
	int     mon_pkts;
	int     tb_errs;
	logic   hung;
	integer seed;

	tb_clock_gen clk_gen (
		.o_clk (clk)
	);

	usb_tx_top uut (
		.clk        (clk),
		.rst        (rst),
		.i_tx_data  (tx_data),
		.i_tx_valid (tx_valid),
		.o_tx_ready (tx_ready),
		.i_phy_mode (phy_mode),
		.o_line     (line)
	);

	usb_tx_monitor mon (
		.clk        (clk),
		.rst        (rst),
		.i_tx_ready (tx_ready),
		.i_phy_mode (phy_mode),
		.i_line     (line),
		.o_errs     (mon_errs),
		.o_pkts     (mon_pkts)
	);

	// About a third all ones, to force stuffing
	function automatic byte_t pick_byte();
		int unsigned r;
		r = $random(seed);
		if (r % 3 == 0)
			return 8'hFF;
		return r[15:8];
	endfunction

	task automatic wait_ready();
		int n;
		n = 0;
		while (!tx_ready && n < READY_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!tx_ready)
		begin
			$display("timed out waiting for o_tx_ready");
			tb_errs++;
			hung = 1'b1;
		end
	endtask

	task automatic send_packet(input int len);
		byte_t b;
		int    i;
		for (i = 0; i < len && !hung; i++)
		begin
			b        = pick_byte();
			tx_data  = b;
			tx_valid = 1'b1;
			wait_ready();
			if (!hung)
			begin
				mon.push_expected(b);
				// Byte is taken at the edge that ends the pulse
				@(negedge clk);
			end
		end
		tx_valid = 1'b0;
	endtask

	task automatic wait_packet(input int count);
		int n;
		n = 0;
		while (mon_pkts < count && n < PKT_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (mon_pkts < count)
		begin
			$display("packet %0d never completed on the line", count);
			tb_errs++;
			hung = 1'b1;
		end
	endtask

	initial
	begin
		int          p;
		int          len;
		int unsigned r;
		seed     = 32'h8d1df6c2;
		rst      = 1'b0;
		tx_data  = '0;
		tx_valid = 1'b0;
		phy_mode = 1'b1;
		tb_errs  = 0;
		hung     = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b1;
		repeat (4) @(negedge clk);

		for (p = 0; p < NUM_PKTS && !hung; p++)
		begin
			r        = $random(seed);
			phy_mode = r[0];
			len      = 1 + int'(r[7:1] % MAX_PKT_LEN);
			repeat (r[10:9]) @(negedge clk);
			send_packet(len);
			if (!hung)
				wait_packet(p + 1);
		end

		repeat (4) @(negedge clk);
		mon.final_check();
		@(negedge clk);
		$display("errors: monitor %0d, assertions %0d, testbench %0d",
			mon_errs, uut.u_props.fail_cnt, tb_errs);
		if (hung || mon_errs != 0 || uut.u_props.fail_cnt != 0 || tb_errs != 0)
			$display("TEST FAILED");
		else
			$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
logic/usb_tx_pkg.sv
logic/tx_serializer.sv
logic/tx_line_driver.sv
logic/tx_packet_fsm.sv
logic/usb_tx_top.sv
testbench/tb_clock_gen.sv
testbench/usb_tx_monitor.sv
testbench/usb_tx_props.sv
testbench/usb_tx_tb.sv
